//--- include/game_cfg.svh
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// LEDs and switches on the board
`define GAME_LED_W 16

// Last round, also the longest sequence
`define GAME_MAX_ROUND 7

// Clock cycles each shown step is held
`define GAME_STEP_CYCLES 8

// Half-period of the game-over flashing
`define GAME_FLASH_CYCLES 8

`define GAME_LFSR_SEED 16'hACE1

`endif

//--- logic/game_pkg.sv
`default_nettype none

package game_pkg;

    typedef enum logic {
        STEP_SWITCH = 1'b0,
        STEP_JOY    = 1'b1
    } step_kind_t;

    typedef enum logic [2:0] {
        DIR_NONE  = 3'd0,
        DIR_UP    = 3'd1,
        DIR_DOWN  = 3'd2,
        DIR_LEFT  = 3'd3,
        DIR_RIGHT = 3'd4
    } dir_t;

    // One step word, read as an LED index or as a direction
    typedef union packed {
        logic [3:0] led_idx;    // Switch step
        struct packed {
            logic pad;          // Always zero
            dir_t dir;
        } joy;                  // Joystick step
    } step_word_t;

    typedef struct packed {
        step_kind_t kind;
        step_word_t word;
    } step_t;

    typedef enum logic [1:0] {
        ST_INIT  = 2'd0,
        ST_SHOW  = 2'd1,
        ST_INPUT = 2'd2,
        ST_OVER  = 2'd3
    } game_state_t;

endpackage

`default_nettype wire

//--- logic/sequence_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

module sequence_store import game_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       gen_start,
    input  logic [2:0] gen_len,
    output logic       gen_done,
    input  logic [2:0] rd_addr_a,
    output step_t      rd_step_a,
    input  logic [2:0] rd_addr_b,
    output step_t      rd_step_b
);

    logic [15:0] lfsr;
    logic        busy;
    logic [2:0]  wr_idx;
    logic [2:0]  len_q;
    step_t       new_step;
    step_t       mem [0:`GAME_MAX_ROUND-1];

    // Free-running Galois LFSR with taps 16, 14, 13 and 11
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= `GAME_LFSR_SEED;
        end else begin
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
    end

    // Build the step for the current write slot
    always_comb begin
        if (len_q <= 3'd3) begin
            new_step.kind = step_kind_t'(lfsr[15]);     // Random kind for short rounds
        end else begin
            new_step.kind = step_kind_t'(wr_idx[0]);    // Switch on even slots
        end
        if (new_step.kind == STEP_JOY) begin
            new_step.word.joy.pad = 1'b0;
            new_step.word.joy.dir = dir_t'({1'b0, lfsr[1:0]} + 3'd1);  // Up..right
        end else begin
            new_step.word.led_idx = lfsr[3:0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            wr_idx   <= 3'd0;
            len_q    <= 3'd0;
            gen_done <= 1'b0;
        end else begin
            gen_done <= 1'b0;
            if (gen_start) begin
                busy   <= 1'b1;
                wr_idx <= 3'd0;
                len_q  <= gen_len;
            end else if (busy) begin
                wr_idx <= wr_idx + 3'd1;
                if (wr_idx == len_q - 3'd1) begin   // Last slot written
                    busy     <= 1'b0;
                    gen_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            mem[wr_idx] <= new_step;
        end
    end

    assign rd_step_a = mem[rd_addr_a];  // Show unit
    assign rd_step_b = mem[rd_addr_b];  // Judge

endmodule

`default_nettype wire

//--- logic/sequence_show.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

module sequence_show import game_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   show_start,
    input  logic [2:0]             show_len,
    output logic                   show_done,
    output logic [2:0]             rd_addr,
    input  step_t                  rd_step,
    output logic                   show_valid,
    output logic [`GAME_LED_W-1:0] show_leds,
    output dir_t                   show_dir
);

    localparam int HOLD_W = $clog2(`GAME_STEP_CYCLES + 1);

    logic              active;
    logic [2:0]        step_idx;
    logic [HOLD_W-1:0] hold;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active    <= 1'b0;
            step_idx  <= 3'd0;
            hold      <= '0;
            show_done <= 1'b0;
        end else begin
            show_done <= 1'b0;
            if (show_start) begin
                active   <= 1'b1;
                step_idx <= 3'd0;
                hold     <= '0;
            end else if (active) begin
                if (hold == HOLD_W'(`GAME_STEP_CYCLES - 1)) begin
                    hold <= '0;
                    if (step_idx == show_len - 3'd1) begin
                        // Done with the sequence
                        active    <= 1'b0;
                        show_done <= 1'b1;
                    end else begin
                        step_idx <= step_idx + 3'd1;   // Next step with no gap
                    end
                end else begin
                    hold <= hold + HOLD_W'(1);
                end
            end
        end
    end

    assign rd_addr    = step_idx;
    assign show_valid = active;

    // Decode the step word for the kind of step
    always_comb begin
        show_leds = '0;
        show_dir  = DIR_NONE;
        if (active) begin
            if (rd_step.kind == STEP_JOY) begin
                show_dir = rd_step.word.joy.dir;
            end else begin
                show_leds = `GAME_LED_W'(1) << rd_step.word.led_idx;   // One lit LED
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/move_judge.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

module move_judge import game_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   judge_enable,
    input  logic [2:0]             judge_len,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic                   in_is_dir,
    input  logic [`GAME_LED_W-1:0] in_switches,
    input  dir_t                   in_dir,
    output logic [2:0]             exp_addr,
    input  step_t                  exp_step,
    output logic                   move_ok,
    output logic                   move_bad,
    output logic                   seq_passed
);

    logic [2:0] pos;
    logic       accept;
    logic       kind_ok;
    logic       value_ok;

    // Low while a verdict is out or after the last step
    assign in_ready = judge_enable && !move_ok && !move_bad && !seq_passed;
    assign accept   = in_valid && in_ready;
    assign exp_addr = pos;

    assign kind_ok = in_is_dir == (exp_step.kind == STEP_JOY);

    always_comb begin
        if (exp_step.kind == STEP_JOY) begin
            value_ok = in_dir == exp_step.word.joy.dir;
        end else begin
            value_ok = in_switches == (`GAME_LED_W'(1) << exp_step.word.led_idx);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pos        <= 3'd0;
            move_ok    <= 1'b0;
            move_bad   <= 1'b0;
            seq_passed <= 1'b0;
        end else begin
            move_ok    <= 1'b0;
            move_bad   <= 1'b0;
            seq_passed <= 1'b0;
            if (!judge_enable) begin
                pos <= 3'd0;                    // Ready for the next input phase
            end else if (accept) begin
                if (kind_ok && value_ok) begin
                    move_ok    <= 1'b1;
                    seq_passed <= pos == judge_len - 3'd1;
                    pos        <= pos + 3'd1;
                end else begin
                    move_bad <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/round_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

module round_fsm import game_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   gen_start,
    input  logic                   gen_done,
    output logic                   show_start,
    input  logic                   show_done,
    output logic                   judge_enable,
    input  logic                   move_bad,
    input  logic                   seq_passed,
    output logic [2:0]             round,
    output logic [2:0]             highest_round,
    output logic                   game_over,
    output logic [`GAME_LED_W-1:0] flash_leds
);

    localparam int FLASH_W = $clog2(`GAME_FLASH_CYCLES + 1);

    game_state_t        state;
    logic               gen_busy;   // Waiting for the store
    logic [2:0]         next_round;
    logic [FLASH_W-1:0] flash_cnt;
    logic               flash_on;

    assign gen_start    = (state == ST_INIT) && !gen_busy;
    assign show_start   = (state == ST_INIT) && gen_done;
    assign judge_enable = state == ST_INPUT;
    assign game_over    = state == ST_OVER;
    assign flash_leds   = {`GAME_LED_W{game_over && flash_on}};

    // Round holds at the limit
    assign next_round = (round == 3'(`GAME_MAX_ROUND)) ? round : round + 3'd1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= ST_INIT;
            gen_busy      <= 1'b0;
            round         <= 3'd1;
            highest_round <= 3'd1;
            flash_cnt     <= '0;
            flash_on      <= 1'b0;
        end else begin
            case (state)
                ST_INIT: begin
                    if (gen_start) begin
                        gen_busy <= 1'b1;
                    end
                    if (gen_done) begin
                        gen_busy <= 1'b0;
                        state    <= ST_SHOW;
                    end
                end
                ST_SHOW: begin
                    if (show_done) begin
                        state <= ST_INPUT;
                    end
                end
                ST_INPUT: begin
                    if (move_bad) begin
                        state     <= ST_OVER;
                        flash_cnt <= '0;
                        flash_on  <= 1'b1;  // Start with LEDs lit
                    end else if (seq_passed) begin
                        round <= next_round;
                        if (next_round > highest_round) begin
                            highest_round <= next_round;
                        end
                        state <= ST_INIT;
                    end
                end
                ST_OVER: begin
                    // Toggle every half-period until reset
                    if (flash_cnt == FLASH_W'(`GAME_FLASH_CYCLES - 1)) begin
                        flash_cnt <= '0;
                        flash_on  <= !flash_on;
                    end else begin
                        flash_cnt <= flash_cnt + FLASH_W'(1);
                    end
                end
                default: state <= ST_INIT;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/game_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

module game_ctrl_top import game_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   show_valid,
    output logic [`GAME_LED_W-1:0] show_leds,
    output dir_t                   show_dir,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic                   in_is_dir,
    input  logic [`GAME_LED_W-1:0] in_switches,
    input  dir_t                   in_dir,
    output logic                   move_ok,
    output logic [2:0]             round,
    output logic [2:0]             highest_round,
    output logic                   game_over,
    output logic [`GAME_LED_W-1:0] flash_leds
);

    logic       gen_start;
    logic       gen_done;
    logic       show_start;
    logic       show_done;
    logic       judge_enable;
    logic       move_bad;
    logic       seq_passed;
    logic [2:0] rd_addr_a;
    step_t      rd_step_a;
    logic [2:0] rd_addr_b;
    step_t      rd_step_b;

    sequence_store sequence_store_inst (
        .clk       (clk),
        .reset     (reset),
        .gen_start (gen_start),
        .gen_len   (round),
        .gen_done  (gen_done),
        .rd_addr_a (rd_addr_a),
        .rd_step_a (rd_step_a),
        .rd_addr_b (rd_addr_b),
        .rd_step_b (rd_step_b)
    );

    sequence_show sequence_show_inst (
        .clk        (clk),
        .reset      (reset),
        .show_start (show_start),
        .show_len   (round),
        .show_done  (show_done),
        .rd_addr    (rd_addr_a),
        .rd_step    (rd_step_a),
        .show_valid (show_valid),
        .show_leds  (show_leds),
        .show_dir   (show_dir)
    );

    move_judge move_judge_inst (
        .clk          (clk),
        .reset        (reset),
        .judge_enable (judge_enable),
        .judge_len    (round),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_is_dir    (in_is_dir),
        .in_switches  (in_switches),
        .in_dir       (in_dir),
        .exp_addr     (rd_addr_b),
        .exp_step     (rd_step_b),
        .move_ok      (move_ok),
        .move_bad     (move_bad),
        .seq_passed   (seq_passed)
    );

    round_fsm round_fsm_inst (
        .clk           (clk),
        .reset         (reset),
        .gen_start     (gen_start),
        .gen_done      (gen_done),
        .show_start    (show_start),
        .show_done     (show_done),
        .judge_enable  (judge_enable),
        .move_bad      (move_bad),
        .seq_passed    (seq_passed),
        .round         (round),
        .highest_round (highest_round),
        .game_over     (game_over),
        .flash_leds    (flash_leds)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    // Reset held for 8 rising edges
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/tb_game.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_cfg.svh"

module tb_game import game_pkg::*; ();

    localparam int ROUND_CYCLES  = `GAME_MAX_ROUND * (`GAME_STEP_CYCLES + 4) + 8;
    localparam int HOLD_CYCLES   = 50;
    localparam int FLASH_CYCLES  = 5 * `GAME_FLASH_CYCLES;
    localparam int TIMEOUT_LIMIT =
        2 * ((`GAME_MAX_ROUND + 1) * ROUND_CYCLES + HOLD_CYCLES + FLASH_CYCLES + 8);

    logic                   clk;
    logic                   reset;
    logic                   show_valid;
    logic [`GAME_LED_W-1:0] show_leds;
    dir_t                   show_dir;
    logic                   in_valid;
    logic                   in_ready;
    logic                   in_is_dir;
    logic [`GAME_LED_W-1:0] in_switches;
    dir_t                   in_dir;
    logic                   move_ok;
    logic [2:0]             round;
    logic [2:0]             highest_round;
    logic                   game_over;
    logic [`GAME_LED_W-1:0] flash_leds;

    logic [18:0] shown[$];      // {leds, dir} per shown step
    logic        verdicts[$];   // Expected verdict per accepted move
    logic [31:0] rng;
    logic        over_seen = 1'b0;
    int          run_len = 0;
    int          cur_round = 1;     // Round of the next showing
    int          cycles = 0;
    int          errors = 0;
    int          test_start_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    tb_clock tb_clock_inst (
        .clk   (clk),
        .reset (reset)
    );

    game_ctrl_top game_ctrl_top_inst (
        .clk           (clk),
        .reset         (reset),
        .show_valid    (show_valid),
        .show_leds     (show_leds),
        .show_dir      (show_dir),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_is_dir     (in_is_dir),
        .in_switches   (in_switches),
        .in_dir        (in_dir),
        .move_ok       (move_ok),
        .round         (round),
        .highest_round (highest_round),
        .game_over     (game_over),
        .flash_leds    (flash_leds)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rng = lfsr_step(rng);
            v = {v[14:0], rng[0]};
        end
        return v;
    endfunction

    // Correct move {is_dir, switches, dir} for a shown step
    function automatic logic [19:0] expected_move(input logic [18:0] step);
        if (step[2:0] != 3'd0) begin
            return {1'b1, 16'h0, step[2:0]};
        end
        return {1'b0, step[18:3], 3'd0};
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    task automatic wait_ready();
        while (!in_ready) @(negedge clk);
    endtask

    task automatic play_move(input logic [19:0] mv, input logic good);
        @(posedge clk);
        #1;
        in_valid    = 1'b1;
        in_is_dir   = mv[19];
        in_switches = mv[18:3];
        in_dir      = dir_t'(mv[2:0]);
        @(negedge clk);
        wait_ready();
        verdicts.push_back(good);   // Accepted at the next edge
        @(posedge clk);
        #1;
        in_valid    = 1'b0;
        in_switches = '0;
        in_dir      = DIR_NONE;
    endtask

    task automatic play_round(input int exp_round);
        logic [18:0] steps[$];
        int          next;
        wait_ready();
        steps = shown;
        next = (exp_round == `GAME_MAX_ROUND) ? exp_round : exp_round + 1;
        check_value(32'(round), exp_round, "round before input");
        check_value(steps.size(), exp_round, "shown step count");
        if (exp_round >= 4) begin
            for (int k = 0; k < steps.size(); k++) begin
                check_value(32'(steps[k][2:0] != 3'd0), k % 2, "step kind alternation");
            end
        end
        for (int k = 0; k < steps.size(); k++) begin
            play_move(expected_move(steps[k]), 1'b1);
        end
        repeat (2) @(negedge clk);
        check_value(32'(round), next, "round after pass");
        check_value(32'(highest_round), next, "highest_round after pass");
        cur_round = next;
    endtask

    task automatic hold_off();
        wait_ready();
        repeat (HOLD_CYCLES) begin
            check_value(32'(in_ready), 1, "in_ready while idle");
            check_value(32'(round), 3, "round while idle");
            @(negedge clk);
        end
    endtask

    task automatic wrong_move_test();
        logic [19:0] mv;
        logic [15:0] flip;
        logic        last_flash;
        int          first;
        int          level_len;
        int          toggles;
        wait_ready();
        // Round 7 opens with a switch step and then a joystick step
        first = int'(take_bits(1));
        if (first == 1) begin
            play_move(expected_move(shown[0]), 1'b1);
        end
        mv = expected_move(shown[first]);
        if (take_bits(1) == 16'd1) begin
            // Move of the other kind
            if (mv[19]) begin
                mv = {1'b0, 16'd1 << take_bits(4), 3'd0};
            end else begin
                mv = {1'b1, 16'd0, 3'(take_bits(2)) + 3'd1};
            end
        end else if (mv[19]) begin
            mv[2:0] = (mv[2:0] % 3'd4) + 3'd1;     // Another direction
        end else begin
            flip = take_bits(16);
            if (flip == 16'd0) begin
                flip = 16'd1;
            end
            mv[18:3] = mv[18:3] ^ flip;
        end
        play_move(mv, 1'b0);
        while (!game_over) @(negedge clk);
        last_flash = flash_leds[0];
        level_len = 0;
        toggles = 0;
        repeat (FLASH_CYCLES) begin
            check_value(32'(in_ready), 0, "in_ready in game over");
            check_value(32'(game_over), 1, "game_over held");
            check_value(32'(flash_leds == '0 || flash_leds == '1), 1, "flash_leds pattern");
            if (flash_leds[0] != last_flash) begin
                check_value(level_len, `GAME_FLASH_CYCLES, "flash half-period");
                toggles++;
                level_len = 0;
                last_flash = flash_leds[0];
            end
            level_len++;
            @(negedge clk);
        end
        check_value(32'(toggles >= 3), 1, "flash toggles seen");
        check_value(32'(round), `GAME_MAX_ROUND, "round after game over");
        check_value(32'(highest_round), `GAME_MAX_ROUND, "highest_round after game over");
    endtask

    // Records each shown step and checks its hold time
    always @(negedge clk) begin
        if (reset) begin
            run_len = 0;
        end else if (show_valid) begin
            if (run_len == 0) begin
                shown.delete();
            end
            if (run_len % `GAME_STEP_CYCLES == 0) begin
                shown.push_back({show_leds, show_dir});
            end
            check_value(32'((show_dir == DIR_NONE) ? ($countones(show_leds) == 1)
                                                   : (show_leds == '0)),
                        1, "one active output per step");
            check_value(32'({show_leds, show_dir} == shown[$]), 1, "step stable in hold");
            run_len++;
        end else if (run_len != 0) begin
            check_value(run_len, cur_round * `GAME_STEP_CYCLES, "show_valid run length");
            run_len = 0;
        end
    end

    // Compares each verdict with the expected one
    always @(negedge clk) begin
        if (!reset && (move_ok || (game_over && !over_seen))) begin
            if (verdicts.size() == 0) begin
                errors++;
                $display("A verdict came at %0t ns with no move accepted", $time);
            end else begin
                check_value(32'(move_ok), 32'(verdicts.pop_front()), "move verdict");
            end
            if (game_over) begin
                over_seen = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        in_valid    = 1'b0;
        in_is_dir   = 1'b0;
        in_switches = '0;
        in_dir      = DIR_NONE;
        rng         = 32'd78232;
        @(negedge clk);
        while (reset) @(negedge clk);

        check_value(32'(round), 1, "round after reset");
        check_value(32'(highest_round), 1, "highest_round after reset");
        check_value(32'(game_over), 0, "game_over after reset");
        check_value(32'(in_ready), 0, "in_ready after reset");
        check_value(32'(move_ok), 0, "move_ok after reset");
        check_value(32'(show_valid), 0, "show_valid after reset");
        check_value(32'(flash_leds), 0, "flash_leds after reset");
        end_test("reset state");

        for (int r = 1; r <= `GAME_MAX_ROUND; r++) begin
            if (r == 3) begin
                hold_off();
                end_test("back-pressure");
            end
            play_round(r);
            end_test($sformatf("round %0d play", r));
        end

        wrong_move_test();
        end_test("wrong move");

        if (verdicts.size() != 0) begin
            errors++;
            $display("%0d accepted moves got no verdict", verdicts.size());
        end
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
logic/game_pkg.sv
logic/sequence_store.sv
logic/sequence_show.sv
logic/move_judge.sv
logic/round_fsm.sv
logic/game_ctrl_top.sv
dv/tb_clock.sv
dv/tb_game.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the game controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_game -Mdir obj_dir -o sim_game -f project.f \
    && ./obj_dir/sim_game > sim.log \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0
